//--- hw/ext_periph_pkg.sv
// ==================================================
// External peripheral definitions: bus widths,
// address map, interrupt lines and register offsets
// ==================================================

package ext_periph_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned NEXT_INT = 4;
  localparam int unsigned N_PERIPH = 2;

  // Offset bits inside one 4 KiB peripheral window
  localparam int unsigned OFFSET_WIDTH = 12;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef enum logic [0:0] {
    PERIPH_GPIO_CNT = 1'b0,
    PERIPH_IFFIFO   = 1'b1
  } periph_idx_e;

  // End address is exclusive
  typedef struct packed {
    periph_idx_e idx;
    addr_t       start_addr;
    addr_t       end_addr;
  } addr_rule_t;

  localparam addr_rule_t EXT_PERIPH_ADDR_RULES[N_PERIPH] = '{
    '{idx: PERIPH_GPIO_CNT, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000},
    '{idx: PERIPH_IFFIFO, start_addr: 32'h0000_1000, end_addr: 32'h0000_2000}
  };

  localparam int unsigned INTR_GPIO_CNT = 0;
  localparam int unsigned INTR_IFFIFO = 1;

  typedef enum logic [OFFSET_WIDTH-1:0] {
    CNT_MAX = 12'h000,
    COUNT   = 12'h004
  } gpio_cnt_reg_e;

  typedef enum logic [OFFSET_WIDTH-1:0] {
    DATA_IN   = 12'h000,
    DATA_OUT  = 12'h004,
    STATUS    = 12'h008,
    WATERMARK = 12'h00C,
    INT_EN    = 12'h010
  } iffifo_reg_e;

endpackage

//--- hw/reg_bus_if.sv
// ==================================================
// Register bus: single-cycle word access with
// valid/ready handshake and error response
// ==================================================

`timescale 1ns/1ps

interface reg_bus_if;

  logic                  valid;
  logic                  write;
  ext_periph_pkg::addr_t addr;
  ext_periph_pkg::data_t wdata;
  ext_periph_pkg::data_t rdata;
  logic                  ready;
  logic                  error;

  modport master (
    output valid, write, addr, wdata,
    input  rdata, ready, error
  );

  modport slave (
    input  valid, write, addr, wdata,
    output rdata, ready, error
  );

endinterface

//--- hw/periph_bus_demux.sv
// ==================================================
// Register bus demux: address decode onto the
// peripheral ports and response merge
// ==================================================

`timescale 1ns/1ps

module periph_bus_demux (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  valid_i,
  input  logic                  write_i,
  input  ext_periph_pkg::addr_t addr_i,
  input  ext_periph_pkg::data_t wdata_i,
  output ext_periph_pkg::data_t rdata_o,
  output logic                  ready_o,
  output logic                  error_o,

  reg_bus_if.master             gpio_bus,
  reg_bus_if.master             fifo_bus
);

  logic [ext_periph_pkg::N_PERIPH-1:0] sel;

  // Range match against the address map
  always_comb begin
    sel = '0;
    for (int i = 0; i < ext_periph_pkg::N_PERIPH; i++) begin
      if (addr_i >= ext_periph_pkg::EXT_PERIPH_ADDR_RULES[i].start_addr &&
          addr_i < ext_periph_pkg::EXT_PERIPH_ADDR_RULES[i].end_addr) begin
        sel[ext_periph_pkg::EXT_PERIPH_ADDR_RULES[i].idx] = 1'b1;
      end
    end
  end

  // Request fan-out, only valid is steered
  assign gpio_bus.valid = valid_i & sel[ext_periph_pkg::PERIPH_GPIO_CNT];
  assign gpio_bus.write = write_i;
  assign gpio_bus.addr  = addr_i;
  assign gpio_bus.wdata = wdata_i;

  assign fifo_bus.valid = valid_i & sel[ext_periph_pkg::PERIPH_IFFIFO];
  assign fifo_bus.write = write_i;
  assign fifo_bus.addr  = addr_i;
  assign fifo_bus.wdata = wdata_i;

  // Response merge; a miss still completes, with an error
  always_comb begin
    rdata_o = '0;
    ready_o = 1'b1;
    error_o = valid_i;
    if (sel[ext_periph_pkg::PERIPH_GPIO_CNT]) begin
      rdata_o = gpio_bus.rdata;
      ready_o = gpio_bus.ready;
      error_o = gpio_bus.error;
    end else if (sel[ext_periph_pkg::PERIPH_IFFIFO]) begin
      rdata_o = fifo_bus.rdata;
      ready_o = fifo_bus.ready;
      error_o = fifo_bus.error;
    end
  end

  // Peripheral windows must never overlap
  a_one_hot_valid: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(gpio_bus.valid && fifo_bus.valid)
  );

endmodule

//--- hw/gpio_event_counter.sv
// ==================================================
// GPIO event counter: counts rising edges, pulses
// the output and raises an interrupt at CNT_MAX
// ==================================================

`timescale 1ns/1ps

module gpio_event_counter (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      gpio_i,
  output logic      gpio_o,
  output logic      intr_o,
  reg_bus_if.slave  bus
);

  ext_periph_pkg::gpio_cnt_reg_e reg_off;
  ext_periph_pkg::data_t         cnt_max_q;
  ext_periph_pkg::data_t         count_q;
  logic [1:0]                    sync_q;
  logic                          prev_q;
  logic                          pulse_q;
  logic                          intr_q;
  logic                          rise;
  logic                          wr_cnt_max;
  logic                          wr_count;

  assign reg_off = ext_periph_pkg::gpio_cnt_reg_e'(bus.addr[ext_periph_pkg::OFFSET_WIDTH-1:0]);

  assign rise       = sync_q[1] & ~prev_q;
  assign wr_cnt_max = bus.valid & bus.write & (reg_off == ext_periph_pkg::CNT_MAX);
  assign wr_count   = bus.valid & bus.write & (reg_off == ext_periph_pkg::COUNT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q    <= '0;
      prev_q    <= 1'b0;
      cnt_max_q <= '0;
      count_q   <= '0;
      pulse_q   <= 1'b0;
      intr_q    <= 1'b0;
    end else begin
      // Two-flop synchronizer, then edge detect
      sync_q  <= {sync_q[0], gpio_i};
      prev_q  <= sync_q[1];
      pulse_q <= 1'b0;
      if (wr_cnt_max) begin
        // New threshold restarts the count
        cnt_max_q <= bus.wdata;
        count_q   <= '0;
      end else if (wr_count) begin
        count_q <= '0;
        intr_q  <= 1'b0;
      end else if (rise && cnt_max_q != '0) begin
        if (count_q == cnt_max_q - 1'b1) begin
          count_q <= '0;
          pulse_q <= 1'b1;
          intr_q  <= 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  assign gpio_o    = pulse_q;
  assign intr_o    = intr_q;
  assign bus.ready = 1'b1;

  always_comb begin
    bus.rdata = '0;
    bus.error = 1'b0;
    case (reg_off)
      ext_periph_pkg::CNT_MAX: bus.rdata = cnt_max_q;
      ext_periph_pkg::COUNT:   bus.rdata = count_q;
      default:                 bus.error = bus.valid;
    endcase
  end

  a_count_below_max: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (cnt_max_q != '0) |-> (count_q < cnt_max_q)
  );

endmodule

//--- hw/iffifo.sv
// ==================================================
// Interfaced FIFO: register-mapped push/pop queue
// with status, DMA slot levels and watermark IRQ
// ==================================================

`timescale 1ns/1ps

module iffifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic      clk_i,
  input  logic      reset_i,
  output logic      in_ready_o,
  output logic      out_valid_o,
  output logic      intr_o,
  reg_bus_if.slave  bus
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned LVL_W = PTR_W + 1;

  ext_periph_pkg::iffifo_reg_e reg_off;
  ext_periph_pkg::data_t       mem_q[FIFO_DEPTH];
  ext_periph_pkg::data_t       watermark_q;
  ext_periph_pkg::data_t       status;
  logic [PTR_W-1:0]            wr_ptr_q;
  logic [PTR_W-1:0]            rd_ptr_q;
  logic [LVL_W-1:0]            level_q;
  logic                        int_en_q;
  logic                        full;
  logic                        empty;
  logic                        push;
  logic                        pop;
  logic                        wr_wm;
  logic                        wr_int_en;

  assign reg_off = ext_periph_pkg::iffifo_reg_e'(bus.addr[ext_periph_pkg::OFFSET_WIDTH-1:0]);

  assign full  = (level_q == LVL_W'(FIFO_DEPTH));
  assign empty = (level_q == '0);

  always_comb begin
    status        = '0;
    status[15:0]  = 16'(level_q);
    status[16]    = full;
    status[17]    = empty;
  end

  // Decode and response in the same cycle
  always_comb begin
    bus.rdata = '0;
    bus.error = 1'b0;
    push      = 1'b0;
    pop       = 1'b0;
    wr_wm     = 1'b0;
    wr_int_en = 1'b0;
    case (reg_off)
      ext_periph_pkg::DATA_IN: begin
        push      = bus.valid & bus.write & ~full;
        bus.error = bus.valid & (~bus.write | full);
      end
      ext_periph_pkg::DATA_OUT: begin
        pop       = bus.valid & ~bus.write & ~empty;
        bus.rdata = empty ? '0 : mem_q[rd_ptr_q];
        bus.error = bus.valid & (bus.write | empty);
      end
      ext_periph_pkg::STATUS: begin
        bus.rdata = status;
        bus.error = bus.valid & bus.write;
      end
      ext_periph_pkg::WATERMARK: begin
        wr_wm     = bus.valid & bus.write;
        bus.rdata = watermark_q;
      end
      ext_periph_pkg::INT_EN: begin
        wr_int_en = bus.valid & bus.write;
        bus.rdata = ext_periph_pkg::data_t'(int_en_q);
      end
      default: bus.error = bus.valid;
    endcase
  end

  assign bus.ready = 1'b1;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= bus.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      level_q     <= '0;
      watermark_q <= '0;
      int_en_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
      if (wr_wm) begin
        watermark_q <= bus.wdata;
      end
      if (wr_int_en) begin
        int_en_q <= bus.wdata[0];
      end
    end
  end

  // DMA slot levels
  assign in_ready_o  = ~full;
  assign out_valid_o = ~empty;

  // Interrupt tracks the registered level
  assign intr_o = int_en_q & (ext_periph_pkg::data_t'(level_q) >= watermark_q);

  a_level_bound: assert property (
    @(posedge clk_i) disable iff (reset_i)
    level_q <= LVL_W'(FIFO_DEPTH)
  );

  // Pointers meet only when the level says full or empty
  a_ptrs_meet_full_or_empty: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (wr_ptr_q == rd_ptr_q) == (full || empty)
  );

endmodule

//--- hw/ext_periph_subsys.sv
// ==================================================
// External peripheral subsystem: bus demux, GPIO
// counter, IFFIFO and interrupt vector
// ==================================================

`timescale 1ns/1ps

module ext_periph_subsys #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  reg_valid_i,
  input  logic                                  reg_write_i,
  input  ext_periph_pkg::addr_t                 reg_addr_i,
  input  ext_periph_pkg::data_t                 reg_wdata_i,
  output ext_periph_pkg::data_t                 reg_rdata_o,
  output logic                                  reg_ready_o,
  output logic                                  reg_error_o,

  input  logic                                  gpio_i,
  output logic                                  gpio_o,
  output logic                                  fifo_in_ready_o,
  output logic                                  fifo_out_valid_o,
  output logic [ext_periph_pkg::NEXT_INT-1:0]   intr_vector_o
);

  logic gpio_cnt_intr;
  logic iffifo_intr;

  reg_bus_if gpio_bus ();
  reg_bus_if fifo_bus ();

  periph_bus_demux periph_bus_demux_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (reg_valid_i),
    .write_i  (reg_write_i),
    .addr_i   (reg_addr_i),
    .wdata_i  (reg_wdata_i),
    .rdata_o  (reg_rdata_o),
    .ready_o  (reg_ready_o),
    .error_o  (reg_error_o),
    .gpio_bus (gpio_bus.master),
    .fifo_bus (fifo_bus.master)
  );

  gpio_event_counter gpio_event_counter_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .intr_o  (gpio_cnt_intr),
    .bus     (gpio_bus.slave)
  );

  iffifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) iffifo_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_ready_o  (fifo_in_ready_o),
    .out_valid_o (fifo_out_valid_o),
    .intr_o      (iffifo_intr),
    .bus         (fifo_bus.slave)
  );

  // Unused lines stay low
  always_comb begin
    intr_vector_o = '0;
    intr_vector_o[ext_periph_pkg::INTR_GPIO_CNT] = gpio_cnt_intr;
    intr_vector_o[ext_periph_pkg::INTR_IFFIFO]   = iffifo_intr;
  end

endmodule

//--- verif/tb_ext_periph_subsys.sv
// ==================================================
// Directed testbench for the external peripheral
// subsystem: FIFO, GPIO counter and address decode
// ==================================================

`timescale 1ns/1ps

module tb_ext_periph_subsys;

  localparam int MAX_CYCLES = 2000;
  localparam ext_periph_pkg::addr_t GPIO_BASE = 32'h0000_0000;
  localparam ext_periph_pkg::addr_t FIFO_BASE = 32'h0000_1000;

  logic                                clk_i;
  logic                                reset_i;
  logic                                reg_valid_i;
  logic                                reg_write_i;
  ext_periph_pkg::addr_t               reg_addr_i;
  ext_periph_pkg::data_t               reg_wdata_i;
  ext_periph_pkg::data_t               reg_rdata_o;
  logic                                reg_ready_o;
  logic                                reg_error_o;
  logic                                gpio_i;
  logic                                gpio_o;
  logic                                fifo_in_ready_o;
  logic                                fifo_out_valid_o;
  logic [ext_periph_pkg::NEXT_INT-1:0] intr_vector_o;

  int     error_count = 0;
  int     cycle_count = 0;
  int     pulse_cycles = 0;
  integer seed = 32'hc1d6;

  ext_periph_subsys #(
    .FIFO_DEPTH (8)
  ) UUT (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .reg_valid_i      (reg_valid_i),
    .reg_write_i      (reg_write_i),
    .reg_addr_i       (reg_addr_i),
    .reg_wdata_i      (reg_wdata_i),
    .reg_rdata_o      (reg_rdata_o),
    .reg_ready_o      (reg_ready_o),
    .reg_error_o      (reg_error_o),
    .gpio_i           (gpio_i),
    .gpio_o           (gpio_o),
    .fifo_in_ready_o  (fifo_in_ready_o),
    .fifo_out_valid_o (fifo_out_valid_o),
    .intr_vector_o    (intr_vector_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("Errors: %0d", error_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Sample gpio_o mid-cycle where it is stable
  always @(negedge clk_i) begin
    if (!reset_i && gpio_o === 1'b1) begin
      pulse_cycles++;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Expected STATUS word for a given level
  function automatic ext_periph_pkg::data_t status_word(input int level);
    ext_periph_pkg::data_t word;
    word = 32'(level);
    word[16] = (level == 8);
    word[17] = (level == 0);
    return word;
  endfunction

  task automatic bus_write(input ext_periph_pkg::addr_t addr, input ext_periph_pkg::data_t data,
                           input logic exp_err);
    @(posedge clk_i);
    #10;
    reg_valid_i = 1'b1;
    reg_write_i = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    #30;
    check_value($sformatf("ready on write to %h", addr), 32'(reg_ready_o), 32'h1);
    check_value($sformatf("error on write to %h", addr), 32'(reg_error_o), 32'(exp_err));
    @(posedge clk_i);
    #10;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic bus_read(input ext_periph_pkg::addr_t addr, output ext_periph_pkg::data_t data,
                          input logic exp_err);
    @(posedge clk_i);
    #10;
    reg_valid_i = 1'b1;
    reg_write_i = 1'b0;
    reg_addr_i  = addr;
    #30;
    data = reg_rdata_o;
    check_value($sformatf("ready on read of %h", addr), 32'(reg_ready_o), 32'h1);
    check_value($sformatf("error on read of %h", addr), 32'(reg_error_o), 32'(exp_err));
    @(posedge clk_i);
    #10;
    reg_valid_i = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #10;
  endtask

  task automatic wait_for_intr(input int bit_idx, input int max_cycles, output logic seen);
    seen = intr_vector_o[bit_idx];
    for (int i = 0; i < max_cycles && !seen; i++) begin
      @(posedge clk_i);
      #10;
      seen = intr_vector_o[bit_idx];
    end
  endtask

  task automatic test_reset_state();
    ext_periph_pkg::data_t rd;
    check_value("fifo_in_ready_o after reset", 32'(fifo_in_ready_o), 32'h1);
    check_value("fifo_out_valid_o after reset", 32'(fifo_out_valid_o), 32'h0);
    check_value("gpio_o after reset", 32'(gpio_o), 32'h0);
    check_value("intr_vector_o after reset", 32'(intr_vector_o), 32'h0);
    bus_read(FIFO_BASE + 32'(ext_periph_pkg::STATUS), rd, 1'b0);
    check_value("STATUS after reset", rd, status_word(0));
    bus_read(GPIO_BASE + 32'(ext_periph_pkg::COUNT), rd, 1'b0);
    check_value("COUNT after reset", rd, 32'h0);
  endtask

  task automatic test_fifo_order();
    ext_periph_pkg::data_t words[$];
    ext_periph_pkg::data_t rd;
    ext_periph_pkg::data_t word;
    for (int i = 0; i < 5; i++) begin
      word = $random(seed);
      words.push_back(word);
      bus_write(FIFO_BASE + 32'(ext_periph_pkg::DATA_IN), word, 1'b0);
    end
    bus_read(FIFO_BASE + 32'(ext_periph_pkg::STATUS), rd, 1'b0);
    check_value("STATUS after five pushes", rd, status_word(5));
    check_value("fifo_out_valid_o with data", 32'(fifo_out_valid_o), 32'h1);
    for (int i = 0; i < 5; i++) begin
      bus_read(FIFO_BASE + 32'(ext_periph_pkg::DATA_OUT), rd, 1'b0);
      check_value($sformatf("pop %0d", i), rd, words.pop_front());
    end
    bus_read(FIFO_BASE + 32'(ext_periph_pkg::STATUS), rd, 1'b0);
    check_value("STATUS after draining", rd, status_word(0));
    check_value("fifo_out_valid_o when empty", 32'(fifo_out_valid_o), 32'h0);
  endtask

  task automatic test_fifo_limits();
    ext_periph_pkg::data_t words[$];
    ext_periph_pkg::data_t rd;
    ext_periph_pkg::data_t word;
    for (int i = 0; i < 8; i++) begin
      word = $random(seed);
      words.push_back(word);
      bus_write(FIFO_BASE + 32'(ext_periph_pkg::DATA_IN), word, 1'b0);
    end
    check_value("fifo_in_ready_o when full", 32'(fifo_in_ready_o), 32'h0);
    bus_read(FIFO_BASE + 32'(ext_periph_pkg::STATUS), rd, 1'b0);
    check_value("STATUS when full", rd, status_word(8));
    // Dropped push must not disturb the stored words
    bus_write(FIFO_BASE + 32'(ext_periph_pkg::DATA_IN), 32'hdead_beef, 1'b1);
    for (int i = 0; i < 8; i++) begin
      bus_read(FIFO_BASE + 32'(ext_periph_pkg::DATA_OUT), rd, 1'b0);
      check_value($sformatf("drain pop %0d", i), rd, words.pop_front());
    end
    bus_read(FIFO_BASE + 32'(ext_periph_pkg::DATA_OUT), rd, 1'b1);
    check_value("rdata of pop when empty", rd, 32'h0);
  endtask

  task automatic test_fifo_irq();
    ext_periph_pkg::data_t words[$];
    ext_periph_pkg::data_t rd;
    ext_periph_pkg::data_t word;
    logic                  seen;
    bus_write(FIFO_BASE + 32'(ext_periph_pkg::WATERMARK), 32'd3, 1'b0);
    bus_write(FIFO_BASE + 32'(ext_periph_pkg::INT_EN), 32'd1, 1'b0);
    for (int i = 0; i < 3; i++) begin
      check_value("FIFO interrupt below watermark", 32'(intr_vector_o[1]), 32'h0);
      word = $random(seed);
      words.push_back(word);
      bus_write(FIFO_BASE + 32'(ext_periph_pkg::DATA_IN), word, 1'b0);
    end
    wait_for_intr(ext_periph_pkg::INTR_IFFIFO, 2, seen);
    check_value("FIFO interrupt at watermark", 32'(seen), 32'h1);
    bus_read(FIFO_BASE + 32'(ext_periph_pkg::DATA_OUT), rd, 1'b0);
    check_value("first pop under interrupt", rd, words.pop_front());
    check_value("FIFO interrupt after one pop", 32'(intr_vector_o[1]), 32'h0);
    bus_write(FIFO_BASE + 32'(ext_periph_pkg::INT_EN), 32'd0, 1'b0);
    for (int i = 0; i < 2; i++) begin
      bus_read(FIFO_BASE + 32'(ext_periph_pkg::DATA_OUT), rd, 1'b0);
      check_value("pop after interrupt", rd, words.pop_front());
    end
  endtask

  task automatic test_gpio_counter();
    ext_periph_pkg::data_t rd;
    bus_write(GPIO_BASE + 32'(ext_periph_pkg::CNT_MAX), 32'd4, 1'b0);
    pulse_cycles = 0;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      #10;
      gpio_i = 1'b1;
      wait_cycles(5);
      gpio_i = 1'b0;
      wait_cycles(5);
      if (i < 3) begin
        bus_read(GPIO_BASE + 32'(ext_periph_pkg::COUNT), rd, 1'b0);
        check_value($sformatf("COUNT after edge %0d", i + 1), rd, 32'(i + 1));
        check_value("GPIO counter interrupt below threshold", 32'(intr_vector_o[0]), 32'h0);
      end
    end
    check_value("cycles with gpio_o high", 32'(pulse_cycles), 32'd1);
    check_value("GPIO counter interrupt", 32'(intr_vector_o[0]), 32'h1);
    bus_read(GPIO_BASE + 32'(ext_periph_pkg::COUNT), rd, 1'b0);
    check_value("COUNT after threshold", rd, 32'h0);
    bus_write(GPIO_BASE + 32'(ext_periph_pkg::COUNT), 32'h0, 1'b0);
    check_value("GPIO counter interrupt after clear", 32'(intr_vector_o[0]), 32'h0);
  endtask

  task automatic test_bad_addr();
    ext_periph_pkg::data_t rd;
    bus_read(32'h0000_3000, rd, 1'b1);
    check_value("rdata of unmapped read", rd, 32'h0);
    bus_read(FIFO_BASE + 32'h20, rd, 1'b1);
  endtask

  initial begin
    reset_i     = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    gpio_i      = 1'b0;
    repeat (5) @(posedge clk_i);
    #10;
    reset_i = 1'b0;

    test_reset_state();
    test_fifo_order();
    test_fifo_limits();
    test_fifo_irq();
    test_gpio_counter();
    test_bad_addr();

    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
hw/ext_periph_pkg.sv
hw/reg_bus_if.sv
hw/periph_bus_demux.sv
hw/gpio_event_counter.sv
hw/iffifo.sv
hw/ext_periph_subsys.sv
verif/tb_ext_periph_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal -f src.f --top-module tb_ext_periph_subsys \
  && ./obj_dir/Vtb_ext_periph_subsys | tee sim.log

grep -q "Simulation FAILED" sim.log && { echo "Testbench reported failure"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0
